/* Makefile */
# build and run the cpu testbench with Verilator

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f compile.f
	@out="$$(./obj_dir/Vcpu_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* common/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// first fetch address after reset
`define CPU_RESET_VECTOR 32'h0000_0000

// data and address width
`define CPU_XLEN 32

// external data bus width
`define CPU_BUS_WIDTH 8

`define CPU_REG_COUNT 32

// pc step per instruction
`define CPU_INSTR_LEN 4

`endif

/* common/cpu_pkg.sv */
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        OP_LOAD    = 5'b00000,
        OP_MISCMEM = 5'b00011,
        OP_OPIMM   = 5'b00100,
        OP_AUIPC   = 5'b00101,
        OP_STORE   = 5'b01000,
        OP_OP      = 5'b01100,
        OP_LUI     = 5'b01101,
        OP_BRANCH  = 5'b11000,
        OP_JALR    = 5'b11001,
        OP_JAL     = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic {
        BUS_READ,
        BUS_WRITE
    } bus_op_e;

    typedef enum logic [2:0] {
        S_RESET,
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_LOAD2,
        S_STORE2,
        S_BRANCH2,
        S_REGWRITE_BUS
    } ctrl_state_e;

    // one bit per branch condition, set from funct3
    typedef struct packed {
        logic geu;
        logic ltu;
        logic ge;
        logic lt;
        logic ne;
        logic eq;
    } branch_mask_t;

endpackage

/* compile.f */
+incdir+common
common/cpu_pkg.sv
design/alu.sv
design/decoder.sv
design/registers.sv
design/bus_wb8.sv
design/cpu_control.sv
design/cpu.sv
test/cpu_properties.sv
test/cpu_tb.sv

/* design/alu.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module alu
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    en,
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    lt,
    output logic    ltu,
    output logic    eq
);

    localparam int SHAMT_W = $clog2(`CPU_XLEN);

    logic [SHAMT_W-1:0] shamt;
    word_t              value;

    // shifts use the low bits of b only
    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            ALU_SUB:  value = a - b;
            ALU_SLL:  value = a << shamt;
            ALU_SLT:  value = word_t'($signed(a) < $signed(b));
            ALU_SLTU: value = word_t'(a < b);
            ALU_XOR:  value = a ^ b;
            ALU_SRL:  value = a >> shamt;
            ALU_SRA:  value = word_t'($signed(a) >>> shamt);
            ALU_OR:   value = a | b;
            ALU_AND:  value = a & b;
            default:  value = a + b;
        endcase
    end

    // result and flags hold until the next enable
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            lt <= 1'b0;
            ltu <= 1'b0;
            eq <= 1'b0;
        end else if (en) begin
            result <= value;
            lt <= $signed(a) < $signed(b);
            ltu <= a < b;
            eq <= a == b;
        end
    end

endmodule

/* design/bus_wb8.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module bus_wb8
    import cpu_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      en,
    input  bus_op_e                   op,
    input  word_t                     addr,
    input  word_t                     wdata,
    output word_t                     rdata,
    output logic                      busy,
    input  logic                      ack,
    input  logic [`CPU_BUS_WIDTH-1:0] dat_rd,
    output word_t                     adr,
    output logic [`CPU_BUS_WIDTH-1:0] dat_wr,
    output logic                      cyc,
    output logic                      stb,
    output logic                      we
);

    localparam int W     = `CPU_BUS_WIDTH;
    localparam int BYTES = `CPU_XLEN / W;

    logic [$clog2(BYTES)-1:0] count;
    word_t                    shift;

    // low byte goes out first, read bytes enter at the top
    assign dat_wr = shift[W-1:0];
    assign rdata = shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cyc <= 1'b0;
            stb <= 1'b0;
            we <= 1'b0;
            count <= '0;
        end else if (!busy) begin
            if (en) begin
                busy <= 1'b1;
                cyc <= 1'b1;
                stb <= 1'b1;
                we <= (op == BUS_WRITE);
                count <= '0;
            end
        end else if (stb) begin
            if (ack) begin
                stb <= 1'b0;
                count <= count + 1'b1;
                // last byte ends the cycle
                if (count == BYTES - 1) begin
                    busy <= 1'b0;
                    cyc <= 1'b0;
                    we <= 1'b0;
                end
            end
        end else begin
            // one idle cycle between bytes
            stb <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (en && !busy) begin
            adr <= addr;
            shift <= wdata;
        end else if (busy && stb && ack) begin
            shift <= {dat_rd, shift[`CPU_XLEN-1:W]};
        end else if (busy && !stb) begin
            adr <= adr + 1'b1;
        end
    end

endmodule

/* design/cpu.sv */
`timescale 1ns/1ns

module cpu
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ack,
    input  logic [7:0] dat_rd,
    output word_t      adr,
    output logic [7:0] dat_wr,
    output logic       cyc,
    output logic       stb,
    output logic       we
);

    logic         alu_en;
    alu_op_e      alu_op;
    word_t        alu_a;
    word_t        alu_b;
    word_t        alu_result;
    logic         alu_lt;
    logic         alu_ltu;
    logic         alu_eq;

    logic         dec_en;
    reg_idx_t     dec_rs1;
    reg_idx_t     dec_rs2;
    reg_idx_t     dec_rd;
    word_t        dec_imm;
    opcode_e      dec_opcode;
    logic [2:0]   dec_funct3;
    logic         dec_funct7_bit5;
    branch_mask_t dec_branch_mask;

    logic         reg_re;
    logic         reg_we;
    word_t        reg_wdata;
    word_t        reg_val1;
    word_t        reg_val2;

    logic         bus_en;
    bus_op_e      bus_op;
    word_t        bus_addr;
    word_t        bus_rdata;
    logic         bus_busy;

    cpu_control control_inst (
        .clk             (clk),
        .reset           (reset),
        .bus_busy        (bus_busy),
        .bus_rdata       (bus_rdata),
        .alu_result      (alu_result),
        .alu_lt          (alu_lt),
        .alu_ltu         (alu_ltu),
        .alu_eq          (alu_eq),
        .dec_opcode      (dec_opcode),
        .dec_funct3      (dec_funct3),
        .dec_funct7_bit5 (dec_funct7_bit5),
        .dec_imm         (dec_imm),
        .dec_branch_mask (dec_branch_mask),
        .reg_val1        (reg_val1),
        .reg_val2        (reg_val2),
        .alu_en          (alu_en),
        .alu_op          (alu_op),
        .alu_a           (alu_a),
        .alu_b           (alu_b),
        .dec_en          (dec_en),
        .reg_re          (reg_re),
        .reg_we          (reg_we),
        .reg_wdata       (reg_wdata),
        .bus_en          (bus_en),
        .bus_op          (bus_op),
        .bus_addr        (bus_addr)
    );

    alu alu_inst (
        .clk    (clk),
        .reset  (reset),
        .en     (alu_en),
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .lt     (alu_lt),
        .ltu    (alu_ltu),
        .eq     (alu_eq)
    );

    // instruction word comes straight from the bus master
    decoder dec_inst (
        .clk         (clk),
        .en          (dec_en),
        .instr       (bus_rdata),
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .rd          (dec_rd),
        .imm         (dec_imm),
        .opcode      (dec_opcode),
        .funct3      (dec_funct3),
        .funct7_bit5 (dec_funct7_bit5),
        .branch_mask (dec_branch_mask)
    );

    registers reg_inst (
        .clk   (clk),
        .re    (reg_re),
        .we    (reg_we),
        .rs1   (dec_rs1),
        .rs2   (dec_rs2),
        .rd    (dec_rd),
        .wdata (reg_wdata),
        .val1  (reg_val1),
        .val2  (reg_val2)
    );

    // store data is taken from read port 2
    bus_wb8 bus_inst (
        .clk    (clk),
        .reset  (reset),
        .en     (bus_en),
        .op     (bus_op),
        .addr   (bus_addr),
        .wdata  (reg_val2),
        .rdata  (bus_rdata),
        .busy   (bus_busy),
        .ack    (ack),
        .dat_rd (dat_rd),
        .adr    (adr),
        .dat_wr (dat_wr),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we)
    );

endmodule

/* design/cpu_control.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_control
    import cpu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         bus_busy,
    input  word_t        bus_rdata,
    input  word_t        alu_result,
    input  logic         alu_lt,
    input  logic         alu_ltu,
    input  logic         alu_eq,
    input  opcode_e      dec_opcode,
    input  logic [2:0]   dec_funct3,
    input  logic         dec_funct7_bit5,
    input  word_t        dec_imm,
    input  branch_mask_t dec_branch_mask,
    input  word_t        reg_val1,
    input  word_t        reg_val2,
    output logic         alu_en,
    output alu_op_e      alu_op,
    output word_t        alu_a,
    output word_t        alu_b,
    output logic         dec_en,
    output logic         reg_re,
    output logic         reg_we,
    output word_t        reg_wdata,
    output logic         bus_en,
    output bus_op_e      bus_op,
    output word_t        bus_addr
);

    typedef enum logic {A_REG1, A_PC} a_sel_e;
    typedef enum logic [1:0] {B_REG2, B_IMM, B_STEP} b_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_BUS, WB_IMM} wb_sel_e;
    typedef enum logic {ADDR_PC, ADDR_ALU} addr_sel_e;

    ctrl_state_e state;
    word_t       pc;
    word_t       pc_next;
    word_t       fetch_addr;
    logic        pc_from_alu;
    logic        wb_alu;
    logic        stall;
    logic        branch_taken;
    a_sel_e      a_sel;
    b_sel_e      b_sel;
    wb_sel_e     wb_sel;
    addr_sel_e   addr_sel;

    // funct3 to ALU operation, alt selects sub and sra
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign branch_taken = (dec_branch_mask.eq & alu_eq) | (dec_branch_mask.ne & ~alu_eq)
        | (dec_branch_mask.lt & alu_lt) | (dec_branch_mask.ge & ~alu_lt)
        | (dec_branch_mask.ltu & alu_ltu) | (dec_branch_mask.geu & ~alu_ltu);

    // jump targets have bit 0 cleared
    assign fetch_addr = pc_from_alu ? {alu_result[`CPU_XLEN-1:1], 1'b0} : pc_next;

    // each state waits for the unit whose result it needs
    always_comb begin
        case (state)
            S_FETCH:                    stall = alu_en | bus_en | bus_busy;
            S_DECODE, S_REGWRITE_BUS:   stall = bus_en | bus_busy;
            S_EXEC:                     stall = reg_re;
            S_LOAD2, S_STORE2, S_BRANCH2: stall = alu_en;
            default:                    stall = 1'b0;
        endcase
    end

    always_comb begin
        alu_a = (a_sel == A_PC) ? pc : reg_val1;
        case (b_sel)
            B_IMM:   alu_b = dec_imm;
            B_STEP:  alu_b = word_t'(`CPU_INSTR_LEN);
            default: alu_b = reg_val2;
        endcase
        case (wb_sel)
            WB_BUS:  reg_wdata = bus_rdata;
            WB_IMM:  reg_wdata = dec_imm;
            default: reg_wdata = alu_result;
        endcase
        bus_addr = (addr_sel == ADDR_PC) ? pc : alu_result;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_RESET;
            alu_en <= 1'b0;
            dec_en <= 1'b0;
            reg_re <= 1'b0;
            reg_we <= 1'b0;
            bus_en <= 1'b0;
            pc_from_alu <= 1'b0;
            wb_alu <= 1'b0;
        end else begin
            // enables are single-cycle pulses
            alu_en <= 1'b0;
            dec_en <= 1'b0;
            reg_re <= 1'b0;
            reg_we <= 1'b0;
            bus_en <= 1'b0;
            alu_op <= ALU_ADD;
            a_sel <= A_REG1;
            b_sel <= B_REG2;
            wb_sel <= WB_ALU;

            if (!stall) begin
                case (state)
                    S_RESET: begin
                        pc_next <= `CPU_RESET_VECTOR;
                        state <= S_FETCH;
                    end

                    S_FETCH: begin
                        // ALU result of the last instruction goes to rd now
                        if (wb_alu) begin
                            reg_we <= 1'b1;
                            wb_alu <= 1'b0;
                        end
                        pc <= fetch_addr;
                        pc_from_alu <= 1'b0;
                        bus_en <= 1'b1;
                        bus_op <= BUS_READ;
                        addr_sel <= ADDR_PC;
                        state <= S_DECODE;
                    end

                    S_DECODE: begin
                        if (dec_en) begin
                            // fields settle after this cycle
                            reg_re <= 1'b1;
                            state <= S_EXEC;
                        end else begin
                            dec_en <= 1'b1;
                            // idle ALU computes pc + 4
                            alu_en <= 1'b1;
                            a_sel <= A_PC;
                            b_sel <= B_STEP;
                        end
                    end

                    S_EXEC: begin
                        pc_next <= alu_result;
                        state <= S_FETCH;
                        case (dec_opcode)
                            OP_OP, OP_OPIMM: begin
                                alu_en <= 1'b1;
                                b_sel <= (dec_opcode == OP_OP) ? B_REG2 : B_IMM;
                                alu_op <= arith_op(dec_funct3, dec_funct7_bit5
                                    && (dec_opcode == OP_OP || dec_funct3 == 3'b101));
                                wb_alu <= 1'b1;
                            end
                            OP_LOAD, OP_STORE: begin
                                // effective address
                                alu_en <= 1'b1;
                                b_sel <= B_IMM;
                                state <= (dec_opcode == OP_LOAD) ? S_LOAD2 : S_STORE2;
                            end
                            OP_JAL, OP_JALR: begin
                                // link is the pc + 4 still held by the ALU
                                reg_we <= 1'b1;
                                alu_en <= 1'b1;
                                a_sel <= (dec_opcode == OP_JAL) ? A_PC : A_REG1;
                                b_sel <= B_IMM;
                                pc_from_alu <= 1'b1;
                            end
                            OP_BRANCH: begin
                                alu_en <= 1'b1;
                                state <= S_BRANCH2;
                            end
                            OP_AUIPC: begin
                                alu_en <= 1'b1;
                                a_sel <= A_PC;
                                b_sel <= B_IMM;
                                wb_alu <= 1'b1;
                            end
                            OP_LUI: begin
                                reg_we <= 1'b1;
                                wb_sel <= WB_IMM;
                            end
                            // fence and unknown opcodes do nothing
                            default: begin
                            end
                        endcase
                    end

                    S_LOAD2: begin
                        bus_en <= 1'b1;
                        bus_op <= BUS_READ;
                        addr_sel <= ADDR_ALU;
                        state <= S_REGWRITE_BUS;
                    end

                    S_STORE2: begin
                        bus_en <= 1'b1;
                        bus_op <= BUS_WRITE;
                        addr_sel <= ADDR_ALU;
                        state <= S_FETCH;
                    end

                    S_BRANCH2: begin
                        // flags are valid, target computed in case it is taken
                        pc_from_alu <= branch_taken;
                        alu_en <= 1'b1;
                        a_sel <= A_PC;
                        b_sel <= B_IMM;
                        state <= S_FETCH;
                    end

                    S_REGWRITE_BUS: begin
                        reg_we <= 1'b1;
                        wb_sel <= WB_BUS;
                        state <= S_FETCH;
                    end
                endcase
            end
        end
    end

endmodule

/* design/decoder.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module decoder
    import cpu_pkg::*;
(
    input  logic         clk,
    input  logic         en,
    input  word_t        instr,
    output reg_idx_t     rs1,
    output reg_idx_t     rs2,
    output reg_idx_t     rd,
    output word_t        imm,
    output opcode_e      opcode,
    output logic [2:0]   funct3,
    output logic         funct7_bit5,
    output branch_mask_t branch_mask
);

    opcode_e      op_in;
    word_t        imm_next;
    branch_mask_t mask_next;

    assign op_in = opcode_e'(instr[6:2]);

    // immediate format follows the opcode
    always_comb begin
        case (op_in)
            OP_STORE:
                imm_next = {{(`CPU_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            OP_BRANCH:
                imm_next = {{(`CPU_XLEN-12){instr[31]}}, instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                imm_next = {instr[31:12], 12'b0};
            OP_JAL:
                imm_next = {{(`CPU_XLEN-20){instr[31]}}, instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default:
                imm_next = {{(`CPU_XLEN-12){instr[31]}}, instr[31:20]};
        endcase
    end

    // empty mask for anything but a branch
    always_comb begin
        mask_next = '0;
        if (op_in == OP_BRANCH) begin
            case (instr[14:12])
                3'b000:  mask_next.eq = 1'b1;
                3'b001:  mask_next.ne = 1'b1;
                3'b100:  mask_next.lt = 1'b1;
                3'b101:  mask_next.ge = 1'b1;
                3'b110:  mask_next.ltu = 1'b1;
                3'b111:  mask_next.geu = 1'b1;
                default: mask_next = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            opcode <= op_in;
            rd <= instr[11:7];
            funct3 <= instr[14:12];
            rs1 <= instr[19:15];
            rs2 <= instr[24:20];
            funct7_bit5 <= instr[30];
            imm <= imm_next;
            branch_mask <= mask_next;
        end
    end

endmodule

/* design/registers.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module registers
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     re,
    input  logic     we,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  word_t    wdata,
    output word_t    val1,
    output word_t    val2
);

    word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        // x0 is never written and always reads as zero
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
        if (re) begin
            val1 <= (rs1 == '0) ? '0 : regs[rs1];
            val2 <= (rs2 == '0) ? '0 : regs[rs2];
        end
    end

endmodule

/* test/cpu_properties.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_properties
    import cpu_pkg::*;
#(
    parameter word_t MARKER_ADDR = '0
) (
    input logic       clk,
    input logic       reset,
    input logic       ack,
    input logic       cyc,
    input logic       stb,
    input logic       we,
    input word_t      adr,
    input logic [7:0] dat_wr
);

    // set by the first strobe after reset
    logic        strobed;
    int unsigned violations = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            strobed <= 1'b0;
        end else if (stb) begin
            strobed <= 1'b1;
        end
    end

    idle_after_reset: assert property (@(posedge clk) reset |=> !cyc && !stb && !we)
        else begin
            violations++;
            $error("bus is not idle after reset");
        end

    first_fetch_at_vector: assert property (@(posedge clk) disable iff (reset)
        stb && !strobed |-> adr == `CPU_RESET_VECTOR)
        else begin
            violations++;
            $error("first strobe is not at the reset vector");
        end

    stb_within_cyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
        else begin
            violations++;
            $error("stb is high while cyc is low");
        end

    // address, direction and write data hold until the ack
    stable_while_waiting: assert property (@(posedge clk) disable iff (reset)
        stb && !ack |=> $stable(adr) && $stable(we) && $stable(dat_wr))
        else begin
            violations++;
            $error("bus outputs changed while waiting for ack");
        end

    next_byte_address: assert property (@(posedge clk) disable iff (reset)
        $rose(stb) && $past(cyc) |-> adr == $past(adr, 2) + 32'd1)
        else begin
            violations++;
            $error("next byte strobe is not at the following address");
        end

    no_wrong_path_store: assert property (@(posedge clk) disable iff (reset)
        !(stb && we && adr[31:2] == MARKER_ADDR[31:2]))
        else begin
            violations++;
            $error("a store on a wrong path reached the marker address");
        end

endmodule

/* test/cpu_tb.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_tb
    import cpu_pkg::*;
();

    localparam word_t OP_A        = 32'h8765_4321;
    localparam word_t OP_B        = 32'h1357_9bd5;
    localparam word_t RESULT_BASE = 32'h0000_0400;
    // wrong-path stores go here, must match the bound checker
    localparam word_t MARKER_ADDR = 32'h0000_07f0;
    localparam int    SLOTS       = 20;
    localparam int    TIMEOUT     = 40000;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       ack = 1'b0;
    logic [7:0] dat_rd = 8'h00;
    word_t      adr;
    logic [7:0] dat_wr;
    logic       cyc;
    logic       stb;
    logic       we;

    logic [7:0] mem [0:4095];
    logic [3:0] written [SLOTS];
    word_t      expected [SLOTS];
    string      names [SLOTS];
    int         slots;
    int         errors = 0;
    word_t      pc_img;
    word_t      halt_addr;
    integer     seed = 32'h4072_e13d;
    logic [1:0] delay = 2'd0;

    cpu uut (
        .clk    (clk),
        .reset  (reset),
        .ack    (ack),
        .dat_rd (dat_rd),
        .adr    (adr),
        .dat_wr (dat_wr),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we)
    );

    bind cpu cpu_properties #(.MARKER_ADDR(32'h0000_07f0)) checks (
        .clk    (clk),
        .reset  (reset),
        .ack    (ack),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_wr (dat_wr)
    );

    always #20 clk = ~clk;

    // byte memory, one ack per strobe after 0 to 3 wait cycles
    always @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            delay <= 2'd0;
        end else if (ack) begin
            ack <= 1'b0;
        end else if (cyc && stb) begin
            if (delay == 2'd0) begin
                ack <= 1'b1;
                delay <= 2'($random(seed));
                if (we) begin
                    mem[adr[11:0]] = dat_wr;
                    if (adr >= RESULT_BASE && adr < RESULT_BASE + 4 * SLOTS) begin
                        written[(adr - RESULT_BASE) >> 2][adr[1:0]] = 1'b1;
                    end
                end else begin
                    dat_rd <= mem[adr[11:0]];
                end
            end else begin
                delay <= delay - 2'd1;
            end
        end
    end

    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2, rs1,
                                     input logic [2:0] f3, input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input logic [12:0] off, input logic [2:0] f3,
                                     input reg_idx_t rs1, rs2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t marker_store();
        return s_type(MARKER_ADDR[11:0], 5'd0, 5'd0);
    endfunction

    // branch conditions as RV32I defines them
    function automatic logic branch_rule(input logic [2:0] f3, input word_t a, b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // only x1 and x2 serve as branch operands
    function automatic word_t reg_value(input reg_idx_t r);
        return (r == 5'd1) ? OP_A : OP_B;
    endfunction

    task automatic emit(input word_t instr);
        word_t a;
        for (int i = 0; i < 4; i++) begin
            a = pc_img + word_t'(i);
            mem[a[11:0]] = instr[8*i +: 8];
        end
        pc_img = pc_img + `CPU_INSTR_LEN;
    endtask

    // lui rounds up when the low part is negative
    task automatic load_const(input reg_idx_t rd, input word_t value);
        word_t upper;
        upper = value + 32'h800;
        emit(u_type(upper[31:12], rd, 7'b0110111));
        emit(i_type(value[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic store_result(input reg_idx_t rs2, input string name, input word_t value);
        emit(s_type(12'(4 * slots), rs2, 5'd31));
        expected[slots] = value;
        names[slots] = name;
        slots++;
    endtask

    task automatic arith_test(input logic [6:0] f7, input logic [2:0] f3, input string name,
                              input word_t value);
        emit(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
        store_result(5'd3, name, value);
    endtask

    // target is always pc + 8, the wrong path holds a marker store
    task automatic branch_test(input logic [2:0] f3, input reg_idx_t rs1, rs2);
        emit(b_type(13'd8, f3, rs1, rs2));
        if (!branch_rule(f3, reg_value(rs1), reg_value(rs2))) begin
            emit(j_type(21'd8, 5'd0));
        end
        emit(marker_store());
    endtask

    task automatic build_program();
        word_t link;
        pc_img = `CPU_RESET_VECTOR;
        slots = 0;
        for (int k = 0; k < SLOTS; k++) begin
            written[k] = 4'b0;
        end
        load_const(5'd31, RESULT_BASE);
        load_const(5'd1, OP_A);
        load_const(5'd2, OP_B);
        arith_test(7'h00, 3'b000, "add", OP_A + OP_B);
        arith_test(7'h20, 3'b000, "sub", OP_A - OP_B);
        arith_test(7'h00, 3'b001, "sll", OP_A << OP_B[4:0]);
        arith_test(7'h00, 3'b010, "slt", {31'b0, $signed(OP_A) < $signed(OP_B)});
        arith_test(7'h00, 3'b011, "sltu", {31'b0, OP_A < OP_B});
        arith_test(7'h00, 3'b100, "xor", OP_A ^ OP_B);
        arith_test(7'h00, 3'b101, "srl", OP_A >> OP_B[4:0]);
        arith_test(7'h20, 3'b101, "sra", word_t'($signed(OP_A) >>> OP_B[4:0]));
        arith_test(7'h00, 3'b110, "or", OP_A | OP_B);
        arith_test(7'h00, 3'b111, "and", OP_A & OP_B);
        emit(i_type(12'hffb, 5'd1, 3'b000, 5'd3, 7'b0010011));
        store_result(5'd3, "addi", OP_A - 32'd5);
        emit(u_type(20'habcde, 5'd3, 7'b0110111));
        store_result(5'd3, "lui", 32'habcd_e000);
        link = pc_img;
        emit(u_type(20'h12345, 5'd3, 7'b0010111));
        store_result(5'd3, "auipc", link + 32'h1234_5000);
        // fence runs as a no-operation
        emit(i_type(12'h0ff, 5'd0, 3'b000, 5'd0, 7'b0001111));
        store_result(5'd1, "sw", OP_A);
        emit(i_type(12'(4 * (slots - 1)), 5'd31, 3'b010, 5'd4, 7'b0000011));
        store_result(5'd4, "lw", OP_A);
        branch_test(3'b000, 5'd1, 5'd1);
        branch_test(3'b000, 5'd1, 5'd2);
        branch_test(3'b001, 5'd1, 5'd2);
        branch_test(3'b001, 5'd2, 5'd2);
        branch_test(3'b100, 5'd1, 5'd2);
        branch_test(3'b100, 5'd2, 5'd1);
        branch_test(3'b101, 5'd2, 5'd1);
        branch_test(3'b101, 5'd1, 5'd2);
        branch_test(3'b110, 5'd2, 5'd1);
        branch_test(3'b110, 5'd1, 5'd2);
        branch_test(3'b111, 5'd1, 5'd2);
        branch_test(3'b111, 5'd2, 5'd1);
        link = pc_img + 32'd4;
        emit(j_type(21'd8, 5'd5));
        emit(marker_store());
        store_result(5'd5, "jal", link);
        // jalr lands past its own marker store, with a nonzero offset
        load_const(5'd6, pc_img + 32'd12);
        link = pc_img + 32'd4;
        emit(i_type(12'd4, 5'd6, 3'b000, 5'd7, 7'b1100111));
        emit(marker_store());
        store_result(5'd7, "jalr", link);
        halt_addr = pc_img;
        emit(j_type(21'd0, 5'd0));
    endtask

    task automatic check_results();
        word_t a;
        word_t actual;
        for (int k = 0; k < slots; k++) begin
            a = RESULT_BASE + word_t'(4 * k);
            actual = {mem[a[11:0] + 12'd3], mem[a[11:0] + 12'd2],
                      mem[a[11:0] + 12'd1], mem[a[11:0]]};
            assert (written[k] == 4'hf) else begin
                errors++;
                $display("Result of %s was not written completely", names[k]);
            end
            assert (actual == expected[k]) else begin
                errors++;
                $display("Mismatch %s: expected %h, actual %h", names[k], expected[k], actual);
            end
        end
    endtask

    initial begin
        int cycles;
        int violations;
        // background pattern over the whole address
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 8'(i ^ (i >> 5) ^ (i >> 9));
        end
        build_program();
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        cycles = 0;
        while (!(stb && !we && adr == halt_addr) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            errors++;
            $display("Timeout: the self-jump at %h was not fetched in %0d cycles",
                     halt_addr, TIMEOUT);
        end else begin
            check_results();
        end

        violations = int'(uut.checks.violations);
        $display("Results checked: %0d, errors: %0d, assertion failures: %0d",
                 slots, errors, violations);
        if (errors == 0 && violations == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
